//--- Bender.yml
package:
  name: elink_tx

sources:
  - elink_pkg.sv
  - epath_dispatch.sv
  - eproc_out_enc8b10b.sv
  - elink_rx_decoder.sv
  - elink_tx_top.sv
  - target: test
    files:
      - elink_tx_assertions.sv
      - tb_elink_tx.sv

//--- all.f
elink_pkg.sv
epath_dispatch.sv
eproc_out_enc8b10b.sv
elink_rx_decoder.sv
elink_tx_top.sv
elink_tx_assertions.sv
tb_elink_tx.sv

//--- elink_pkg.sv
// E-link package: lane byte and status types, 8b10b code tables, protocol constants
package elink_pkg;

  // One byte as it travels to a lane or comes out of the decoder
  typedef struct packed {
    logic       is_k;  // Control character
    logic [7:0] data;  // HGF EDCBA
  } lane_byte_t;

  typedef struct packed {
    lane_byte_t hi;  // Goes out first
    lane_byte_t lo;
  } epath_word_t;

  typedef struct packed {
    logic       valid;     // One cycle per non-comma symbol
    logic       ko;        // K character received
    logic       code_err;  // Sub-block not in the tables
    logic       disp_err;  // Running disparity broken
    logic [7:0] data;
  } rx_status_t;

  localparam int unsigned SYMBOL_BITS       = 10;
  localparam int unsigned BITS_PER_CYCLE    = 2;
  localparam int unsigned CYCLES_PER_SYMBOL = 5;

  localparam lane_byte_t K28_5 = '{is_k: 1'b1, data: 8'hBC};  // Comma, also the idle filler

  localparam logic [5:0] K28_6B = 6'b001111;  // abcdei of every K28.y, RD- form
  localparam logic [SYMBOL_BITS-1:0] K28_5_RDN = {K28_6B, 4'b1010};
  localparam logic [SYMBOL_BITS-1:0] K28_5_RDP = ~K28_5_RDN;

  // 5b/6b data codes, RD- column, index is EDCBA
  localparam logic [5:0] CODE6_RDN [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
  };

  // 3b/4b fghj for RD- ahead of the sub-block; y = 7 is the primary P7 form
  localparam logic [3:0] CODE4_D_RDN [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
  };
  localparam logic [3:0] CODE4_K_RDN [8] = '{
    4'b1011, 4'b0110, 4'b1010, 4'b1100, 4'b1101, 4'b0101, 4'b1001, 4'b0111
  };

  // K23.7, K27.7, K29.7, K30.7 share their 6b code with data
  function automatic logic is_kx7(input logic [4:0] x);
    return (x == 5'd23) || (x == 5'd27) || (x == 5'd29) || (x == 5'd30);
  endfunction

endpackage

//--- elink_rx_decoder.sv
// Loopback receiver: comma alignment, 10b8b decoding and error checks for every lane
module elink_rx_decoder
  import elink_pkg::*;
#(
  parameter int unsigned NUM_LANES = 4
)
(
  input  logic                                          getDataTrig,
  input  logic                                          rst_n,
  input  logic       [NUM_LANES-1:0][BITS_PER_CYCLE-1:0] edata,
  output rx_status_t [NUM_LANES-1:0]                    rx_status,
  output logic       [NUM_LANES-1:0]                    rx_sync
);

  localparam int unsigned WIN_BITS = SYMBOL_BITS + BITS_PER_CYCLE;
  localparam int unsigned PH_W     = $clog2(CYCLES_PER_SYMBOL);
  localparam logic [PH_W-1:0] PH_LAST = PH_W'(CYCLES_PER_SYMBOL - 1);

  logic       [NUM_LANES-1:0][WIN_BITS-1:0] win;  // Newest bits at the bottom
  logic       [NUM_LANES-1:0][PH_W-1:0]     ph;   // 0 = aligned symbol in win top
  logic       [NUM_LANES-1:0]               rd_pos;
  logic       [NUM_LANES-1:0]               comma_at;
  rx_status_t [NUM_LANES-1:0]               dec;
  logic       [NUM_LANES-1:0]               dec_rd;

  always_comb
  begin
    logic [5:0] s6;
    logic [3:0] s4;
    logic [3:0] c4;
    logic [4:0] x;
    logic [2:0] y;
    logic       ok6;
    logic       ok4;
    logic       k28;
    logic       kx7;
    logic       rdm;
    logic       d_err;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      // Comma search on the newest 10 bits, one even offset per cycle
      comma_at[i] = (win[i][SYMBOL_BITS-1:0] == K28_5_RDN) ||
                    (win[i][SYMBOL_BITS-1:0] == K28_5_RDP);

      {s6, s4} = win[i][WIN_BITS-1 -: SYMBOL_BITS];
      k28 = (s6 == K28_6B) || (s6 == ~K28_6B);
      x   = 5'd28;
      ok6 = k28;
      for (int v = 0; v < 32; v++)
      begin
        if (s6 == CODE6_RDN[v] ||
            (s6 == ~CODE6_RDN[v] && ($countones(CODE6_RDN[v]) != 3 || v == 7)))
        begin
          x   = 5'(v);
          ok6 = 1'b1;
        end
      end

      rdm = rd_pos[i] ^ ($countones(s6) != 3);
      y   = 3'd7;
      ok4 = 1'b0;
      for (int v = 0; v < 8; v++)
      begin
        c4 = k28 ? CODE4_K_RDN[v] : CODE4_D_RDN[v];
        // K28 sets its own middle disparity
        if (k28 ? (s4 == ((s6 == K28_6B) ? ~c4 : c4))
                : (s4 == c4 || (s4 == ~c4 && ($countones(c4) != 2 || v == 3))))
        begin
          y   = 3'(v);
          ok4 = 1'b1;
        end
      end
      if (!k28 && (s4 == 4'b0111 || s4 == 4'b1000))
        ok4 = 1'b1;  // A7 or K.x.7, y stays 7
      kx7 = !k28 && is_kx7(x) && (s4 == 4'b0111 || s4 == 4'b1000);

      // Unbalanced sub-blocks must oppose the running disparity
      d_err = 1'b0;
      if ($countones(s6) == 4 || s6 == 6'b111000)
        d_err = d_err | rd_pos[i];
      if ($countones(s6) == 2 || s6 == 6'b000111)
        d_err = d_err | !rd_pos[i];
      if ($countones(s4) == 3 || s4 == 4'b1100)
        d_err = d_err | rdm;
      if ($countones(s4) == 1 || s4 == 4'b0011)
        d_err = d_err | !rdm;

      dec[i].valid    = !(k28 && y == 3'd5);  // Idle commas stay silent
      dec[i].ko       = k28 || kx7;
      dec[i].code_err = !(ok6 && ok4);
      dec[i].disp_err = d_err;
      dec[i].data     = {y, x};
      dec_rd[i]       = rdm ^ ($countones(s4) != 2);
    end
  end

  // Bit window
  always_ff @(posedge getDataTrig)
  begin
    for (int i = 0; i < NUM_LANES; i++)
      win[i] <= {win[i][WIN_BITS-BITS_PER_CYCLE-1:0], edata[i]};
  end

  always_ff @(posedge getDataTrig)
  begin
    if (!rst_n)
    begin
      ph        <= '0;
      rd_pos    <= '0;
      rx_sync   <= '0;
      rx_status <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
        rx_status[i] <= '0;  // Flags pulse with the symbol
        if (!rx_sync[i])
        begin
          if (comma_at[i])
          begin
            rx_sync[i] <= 1'b1;
            ph[i]      <= '0;  // Comma is decoded next cycle
            rd_pos[i]  <= (win[i][SYMBOL_BITS-1:0] == K28_5_RDP);  // RD ahead of it
          end
        end
        else
        begin
          ph[i] <= (ph[i] == PH_LAST) ? '0 : ph[i] + 1'b1;
          if (ph[i] == '0)
          begin
            rx_status[i] <= dec[i];
            rd_pos[i]    <= dec_rd[i];
          end
        end
      end
    end
  end

endmodule

//--- elink_tx_assertions.sv
// Bound checks on the e-group top: full in reset, receiver error flags and valid without sync
module elink_tx_assertions
  import elink_pkg::*;
#(
  parameter int unsigned NUM_LANES = 4
)
(
  input logic                         getDataTrig,
  input logic                         rst_n,
  input logic                         full,
  input rx_status_t [NUM_LANES-1:0]   rx_status,
  input logic       [NUM_LANES-1:0]   rx_sync
);

  logic [NUM_LANES-1:0] lane_err;  // code_err or disp_err
  logic [NUM_LANES-1:0] lane_vld;

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      lane_err[i] = rx_status[i].code_err | rx_status[i].disp_err;
      lane_vld[i] = rx_status[i].valid;
    end
  end

  // Buffers empty one edge into reset
  full_in_reset: assert property (@(posedge getDataTrig) !rst_n |=> !full)
    else $error("full is high during reset");

  no_err_after_sync: assert property (@(posedge getDataTrig) disable iff (!rst_n)
    (lane_err & rx_sync) == '0)
    else $error("code or disparity error on a synchronized lane");

  valid_needs_sync: assert property (@(posedge getDataTrig) disable iff (!rst_n)
    (lane_vld & ~rx_sync) == '0)
    else $error("rx_status valid on a lane without rx_sync");

endmodule

bind elink_tx_top elink_tx_assertions #(
  .NUM_LANES (NUM_LANES)
) u_assertions (
  .getDataTrig (getDataTrig),
  .rst_n       (rst_n),
  .full        (full),
  .rx_status   (rx_status),
  .rx_sync     (rx_sync)
);

//--- elink_tx_top.sv
// E-link transmit e-group top: dispatcher, 8b10b output lanes and loopback decoder
module elink_tx_top
  import elink_pkg::*;
#(
  parameter int unsigned NUM_LANES = 4
)
(
  input  logic                                          getDataTrig,
  input  logic                                          rst_n,
  input  epath_word_t                                   word_in,
  input  logic                                          word_strobe,
  output logic                                          full,
  output logic       [NUM_LANES-1:0][BITS_PER_CYCLE-1:0] edata_out,  // Toward the GBTX
  output rx_status_t [NUM_LANES-1:0]                    rx_status,
  output logic       [NUM_LANES-1:0]                    rx_sync
);

  logic       [NUM_LANES-1:0] get_data;   // Lane byte requests
  logic       [NUM_LANES-1:0] data_rdy;
  lane_byte_t [NUM_LANES-1:0] lane_byte;

  epath_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .getDataTrig (getDataTrig),
    .rst_n       (rst_n),
    .word_in     (word_in),
    .word_strobe (word_strobe),
    .full        (full),
    .get_data    (get_data),
    .data_rdy    (data_rdy),
    .lane_byte   (lane_byte)
  );

  for (genvar g = 0; g < NUM_LANES; g++)
  begin : g_lane
    eproc_out_enc8b10b u_lane (
      .getDataTrig (getDataTrig),
      .rst_n       (rst_n),
      .data_rdy    (data_rdy[g]),
      .lane_byte   (lane_byte[g]),
      .get_data    (get_data[g]),
      .edata       (edata_out[g])
    );
  end

  // Loopback on the serial lines
  elink_rx_decoder #(
    .NUM_LANES (NUM_LANES)
  ) u_rx (
    .getDataTrig (getDataTrig),
    .rst_n       (rst_n),
    .edata       (edata_out),
    .rx_status   (rx_status),
    .rx_sync     (rx_sync)
  );

endmodule

//--- epath_dispatch.sv
// E-path dispatcher: round-robin word buffers per lane, serves bytes on lane request
module epath_dispatch
  import elink_pkg::*;
#(
  parameter int unsigned NUM_LANES = 4
)
(
  input  logic                         getDataTrig,
  input  logic                         rst_n,
  input  epath_word_t                  word_in,
  input  logic                         word_strobe,
  output logic                         full,
  input  logic       [NUM_LANES-1:0]   get_data,
  output logic       [NUM_LANES-1:0]   data_rdy,
  output lane_byte_t [NUM_LANES-1:0]   lane_byte
);

  localparam int unsigned PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(NUM_LANES - 1);

  logic        [PTR_W-1:0]     wr_ptr;     // Lane that takes the next word
  epath_word_t [NUM_LANES-1:0] buf_word;   // One word per lane
  logic        [NUM_LANES-1:0] buf_vld;
  logic        [NUM_LANES-1:0] half_done;  // High byte already served
  logic                        accept;

  assign full   = buf_vld[wr_ptr];  // Target lane still busy
  assign accept = word_strobe && !full;  // Strobe while full is lost

  // Control state
  always_ff @(posedge getDataTrig)
  begin
    if (!rst_n)
    begin
      wr_ptr    <= '0;
      buf_vld   <= '0;
      half_done <= '0;
      data_rdy  <= '0;
    end
    else
    begin
      if (accept)
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;  // Strict round-robin
      for (int i = 0; i < NUM_LANES; i++)
      begin
        data_rdy[i] <= get_data[i];  // Always answered, one cycle later
        if (accept && wr_ptr == PTR_W'(i))
          buf_vld[i] <= 1'b1;
        if (get_data[i] && buf_vld[i])
        begin
          half_done[i] <= !half_done[i];
          if (half_done[i])
            buf_vld[i] <= 1'b0;  // Low byte gone, buffer free
        end
      end
    end
  end

  // Word storage and byte select
  always_ff @(posedge getDataTrig)
  begin
    if (accept)
      buf_word[wr_ptr] <= word_in;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      if (get_data[i])
        lane_byte[i] <= !buf_vld[i] ? K28_5 :          // Nothing queued, idle comma
                        half_done[i] ? buf_word[i].lo : buf_word[i].hi;
    end
  end

endmodule

//--- eproc_out_enc8b10b.sv
// E-link output lane: byte request, 8b10b encoding with running disparity, 2-bit serializer
module eproc_out_enc8b10b
  import elink_pkg::*;
(
  input  logic                      getDataTrig,
  input  logic                      rst_n,
  input  logic                      data_rdy,
  input  lane_byte_t                lane_byte,
  output logic                      get_data,
  output logic [BITS_PER_CYCLE-1:0] edata
);

  localparam int unsigned PH_W = $clog2(CYCLES_PER_SYMBOL);
  localparam logic [PH_W-1:0] PH_LAST = PH_W'(CYCLES_PER_SYMBOL - 1);

  logic [PH_W-1:0]        ph;        // Symbol phase
  lane_byte_t             cur_byte;  // Byte for the next symbol
  logic                   rd_pos;    // Running disparity, 1 = positive
  logic [SYMBOL_BITS-1:0] sr;        // Bit a at the top

  lane_byte_t             enc_in;
  logic                   k_valid;
  logic [4:0]             x;  // EDCBA
  logic [2:0]             y;  // HGF
  logic [5:0]             c6;
  logic [3:0]             c4;
  logic                   rd_mid;  // Disparity between the sub-blocks
  logic                   rd_next;
  logic                   alt7;
  logic [SYMBOL_BITS-1:0] sym;

  // Unknown K codes fall back to the comma
  assign k_valid = (cur_byte.data[4:0] == 5'd28) ||
                   (cur_byte.data[7:5] == 3'd7 && is_kx7(cur_byte.data[4:0]));
  assign enc_in  = (cur_byte.is_k && !k_valid) ? K28_5 : cur_byte;
  assign x       = enc_in.data[4:0];
  assign y       = enc_in.data[7:5];

  always_comb
  begin
    // 5b/6b
    c6 = (enc_in.is_k && x == 5'd28) ? K28_6B : CODE6_RDN[x];
    if (rd_pos && ($countones(c6) != 3 || x == 5'd7))
      c6 = ~c6;  // Positive form, D.7 included
    rd_mid = rd_pos ^ ($countones(c6) != 3);

    // 3b/4b, A7 avoids a run of five
    alt7 = rd_mid ? (x == 5'd11 || x == 5'd13 || x == 5'd14)
                  : (x == 5'd17 || x == 5'd18 || x == 5'd20);
    c4 = enc_in.is_k ? CODE4_K_RDN[y] : CODE4_D_RDN[y];
    if (!enc_in.is_k && y == 3'd7 && alt7)
      c4 = 4'b0111;
    if (rd_mid && (enc_in.is_k || $countones(c4) != 2 || y == 3'd3))
      c4 = ~c4;  // K codes always take the positive column here
    rd_next = rd_mid ^ ($countones(c4) != 2);
  end

  assign sym   = {c6, c4};  // abcdei fghj
  assign edata = sr[SYMBOL_BITS-1 -: BITS_PER_CYCLE];  // a,b first

  always_ff @(posedge getDataTrig)
  begin
    if (!rst_n)
    begin
      ph       <= '0;
      get_data <= 1'b0;
      cur_byte <= K28_5;  // Idle until first answer
      rd_pos   <= 1'b0;   // Start at RD-
      sr       <= '0;
    end
    else
    begin
      ph       <= (ph == PH_LAST) ? '0 : ph + 1'b1;
      get_data <= (ph == PH_LAST);  // High during phase 0
      if (data_rdy)
        cur_byte <= lane_byte;  // Lands at phase 1
      if (ph == PH_LAST)
      begin
        sr     <= sym;  // New symbol from phase 0
        rd_pos <= rd_next;
      end
      else
      begin
        sr <= sr << BITS_PER_CYCLE;
      end
    end
  end

endmodule

//--- tb_elink_tx.sv
// Testbench for the E-link transmit e-group that checks table-driven words per lane at the loopback
module tb_elink_tx
  import elink_pkg::*;
();

  localparam int unsigned NUM_LANES     = 4;
  localparam int unsigned NUM_STIM      = 24;
  localparam int unsigned NUM_RANDOM    = 32;  // Back-to-back padding words
  localparam int unsigned SYNC_TIMEOUT  = 100;
  localparam int unsigned FULL_TIMEOUT  = 200;
  localparam int unsigned DRAIN_TIMEOUT = 2000;
  localparam int unsigned QUIET_CYCLES  = 60;
  localparam int          LINE_RDS_MAX  = 6;  // 8b10b digital sum variation
  localparam logic D = 1'b0;  // Data byte
  localparam logic K = 1'b1;  // Control byte

  // hi flag, hi byte, lo flag, lo byte
  // No K28.5 in the table since it reads as idle
  localparam logic [17:0] STIM_WORD [NUM_STIM] = '{
    {D, 8'h12, D, 8'h34}, {D, 8'hA5, D, 8'h5A}, {K, 8'h1C, D, 8'h00}, {D, 8'hFF, K, 8'h3C},
    {D, 8'hF1, D, 8'hEB}, {K, 8'h5C, K, 8'h7C}, {D, 8'hBC, D, 8'h7C}, {K, 8'h9C, D, 8'hE7},
    {D, 8'hF2, D, 8'hF4}, {K, 8'hDC, K, 8'hFC}, {K, 8'hF7, K, 8'hFB}, {K, 8'hFD, K, 8'hFE},
    {D, 8'hED, D, 8'hEE}, {D, 8'h01, D, 8'h80}, {D, 8'h55, D, 8'hAA}, {D, 8'h0F, D, 8'hF0},
    {D, 8'hC3, D, 8'h3C}, {D, 8'h7E, D, 8'h81}, {D, 8'hE0, K, 8'h1C}, {D, 8'h6B, D, 8'h94},
    {D, 8'hFE, D, 8'hFD}, {K, 8'h3C, K, 8'h3C}, {D, 8'hB5, D, 8'h4A}, {D, 8'h00, D, 8'h00}
  };
  // Idle cycles ahead of each word (zero for back-to-back)
  localparam int unsigned STIM_GAP [NUM_STIM] = '{
    2, 0, 0, 0, 0, 0, 7, 1, 0, 0, 0, 0, 13, 3, 0, 0, 0, 0, 0, 0, 21, 0, 0, 0
  };

  logic                                          getDataTrig;
  logic                                          rst_n;
  epath_word_t                                   word_in;
  logic                                          word_strobe;
  logic                                          full;
  logic       [NUM_LANES-1:0][BITS_PER_CYCLE-1:0] edata_out;
  rx_status_t [NUM_LANES-1:0]                    rx_status;
  logic       [NUM_LANES-1:0]                    rx_sync;

  lane_byte_t  exp_q [NUM_LANES][$];  // Bytes still owed per lane
  int          line_rds [NUM_LANES];  // Line ones minus zeros since rx_sync
  int unsigned mismatches;
  int unsigned other_errors;
  int unsigned word_cnt;  // Accepted word count that picks the lane
  logic        full_seen;
  logic        timed_out;
  logic [31:0] rng;

  elink_tx_top #(
    .NUM_LANES (NUM_LANES)
  ) u_dut (
    .getDataTrig (getDataTrig),
    .rst_n       (rst_n),
    .word_in     (word_in),
    .word_strobe (word_strobe),
    .full        (full),
    .edata_out   (edata_out),
    .rx_status   (rx_status),
    .rx_sync     (rx_sync)
  );

  initial
  begin
    getDataTrig = 1'b0;
    forever #5 getDataTrig = ~getDataTrig;
  end

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic int unsigned pending_bytes();
    int unsigned n;
    n = 0;
    for (int l = 0; l < NUM_LANES; l++)
      n += exp_q[l].size();
    return n;
  endfunction

  task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] want);
    if (got !== want)
    begin
      mismatches++;
      $display("Mismatch at time %0t: %s got %0h expected %0h", $time, what, got, want);
    end
  endtask

  task automatic finish_run();
    $display("Closing count: %0d mismatches, %0d other errors", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  endtask

  task automatic note_timeout(input string what);
    other_errors++;
    timed_out = 1'b1;
    $display("Error at time %0t: timed out waiting for %s", $time, what);
  endtask

  // Strobe one word once the target lane is free and record its bytes for that lane
  task automatic send_word(input epath_word_t w);
    int unsigned cnt;
    cnt = 0;
    while (full && cnt < FULL_TIMEOUT)
    begin
      @(negedge getDataTrig);
      cnt++;
    end
    if (full)
      note_timeout("full to drop");
    else
    begin
      word_in     = w;
      word_strobe = 1'b1;
      exp_q[word_cnt % NUM_LANES].push_back(w.hi);  // High byte goes first
      exp_q[word_cnt % NUM_LANES].push_back(w.lo);
      word_cnt++;
      @(negedge getDataTrig);
      word_strobe = 1'b0;
    end
  endtask

  // Scoreboard on the loopback outputs
  always @(negedge getDataTrig)
  begin
    lane_byte_t e;
    if (rst_n === 1'b1)
    begin
      if (full)
        full_seen = 1'b1;
      for (int l = 0; l < NUM_LANES; l++)
      begin
        check_value($sformatf("lane %0d code/disp error flags", l),
                    {rx_status[l].code_err, rx_status[l].disp_err}, 16'h0);
        if (rx_sync[l])
        begin
          line_rds[l] += 2 * $countones(edata_out[l]) - 2;  // Two bits per cycle
          if (line_rds[l] > LINE_RDS_MAX || line_rds[l] < -LINE_RDS_MAX)
          begin
            other_errors++;
            $display("Error at time %0t: lane %0d serial line lost its DC balance", $time, l);
            line_rds[l] = 0;
          end
        end
        if (rx_status[l].valid && exp_q[l].size() == 0)
        begin
          other_errors++;
          $display("Error at time %0t: lane %0d delivered byte %0h that was never sent",
                   $time, l, rx_status[l].data);
        end
        else if (rx_status[l].valid)
        begin
          e = exp_q[l].pop_front();
          check_value($sformatf("lane %0d {ko,data}", l),
                      {rx_status[l].ko, rx_status[l].data}, {e.is_k, e.data});
        end
      end
    end
  end

  initial
  begin
    int unsigned cnt;
    epath_word_t w;
    rst_n        = 1'b0;
    word_in      = '0;
    word_strobe  = 1'b0;
    mismatches   = 0;
    other_errors = 0;
    word_cnt     = 0;
    full_seen    = 1'b0;
    timed_out    = 1'b0;
    rng          = 32'd86;
    repeat (3) @(negedge getDataTrig);
    rst_n = 1'b1;

    check_value("full after reset", full, 16'h0);
    check_value("rx_sync after reset", rx_sync, 16'h0);
    for (int l = 0; l < NUM_LANES; l++)
      check_value($sformatf("lane %0d valid after reset", l), rx_status[l].valid, 16'h0);

    // Idle commas alone must lock every lane
    cnt = 0;
    while (rx_sync != '1 && cnt < SYNC_TIMEOUT)
    begin
      @(negedge getDataTrig);
      cnt++;
    end
    if (rx_sync != '1)
      note_timeout("rx_sync on every lane");

    for (int i = 0; i < NUM_STIM && !timed_out; i++)
    begin
      repeat (STIM_GAP[i]) @(negedge getDataTrig);
      send_word(epath_word_t'(STIM_WORD[i]));
    end
    for (int i = 0; i < NUM_RANDOM && !timed_out; i++)
    begin
      rng = next_random(rng);
      w   = '{hi: '{is_k: 1'b0, data: rng[7:0]}, lo: '{is_k: 1'b0, data: rng[15:8]}};
      send_word(w);
    end

    cnt = 0;
    while (!timed_out && pending_bytes() != 0 && cnt < DRAIN_TIMEOUT)
    begin
      @(negedge getDataTrig);
      cnt++;
    end
    if (!timed_out && pending_bytes() != 0)
      note_timeout("all expected bytes to arrive");
    if (!timed_out)
    begin
      repeat (QUIET_CYCLES) @(negedge getDataTrig);  // Stray bytes would show up here
      if (!full_seen)
      begin
        other_errors++;
        $display("Error: full never rose during back-to-back words");
      end
    end
    finish_run();
  end

endmodule
